// ==== source/botAggregatePkg.sv ====
package botAggregatePkg;

    // One truth table per bot
    localparam int BOT_WIDTH = 32;

    // Bots per batch, up to 1023
    localparam int COUNT_WIDTH = 10;

    // Room for 32 true entries per bot over a full batch
    localparam int SUM_WIDTH = COUNT_WIDTH + 6;

    typedef logic [BOT_WIDTH-1:0] botT;

    typedef struct packed {
        logic [SUM_WIDTH-1:0]   sum;
        logic [COUNT_WIDTH-1:0] count;
    } batchResultT;

    // Lane either gathers a batch or offers its finished totals
    typedef enum logic {
        laneCollecting,
        laneHolding
    } laneStateT;

    // Whether the current lane has seen the first bot of a batch
    typedef enum logic {
        dispatchIdle,
        dispatchInBatch
    } dispatchStateT;

endpackage

// ==== source/streamIfs.sv ====
`timescale 1ns/1ps

// Bots from the dispatcher into one lane
interface botStreamIf import botAggregatePkg::*;;
    logic valid;
    logic ready;
    botT  bot;
    logic last;

    modport source (
        output valid,
        output bot,
        output last,
        input  ready
    );

    modport sink (
        input  valid,
        input  bot,
        input  last,
        output ready
    );
endinterface

// Finished batch totals from one lane into the collector
interface resultStreamIf import botAggregatePkg::*;;
    logic                   valid;
    logic                   ready;
    logic [SUM_WIDTH-1:0]   sum;
    logic [COUNT_WIDTH-1:0] count;

    modport source (
        output valid,
        output sum,
        output count,
        input  ready
    );

    modport sink (
        input  valid,
        input  sum,
        input  count,
        output ready
    );
endinterface

// ==== source/batchDispatcher.sv ====
`timescale 1ns/1ps

module batchDispatcher import botAggregatePkg::*; #(
    parameter int LANE_COUNT = 4
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       inValid,
    input  logic       inLast,
    input  botT        inBot,
    output logic       inReady,
    botStreamIf.source lanes [LANE_COUNT]
);

    localparam int PTR_WIDTH = (LANE_COUNT > 1) ? $clog2(LANE_COUNT) : 1;

    dispatchStateT         state;
    logic [PTR_WIDTH-1:0]  lanePtr;
    logic [LANE_COUNT-1:0] laneValid;
    logic [LANE_COUNT-1:0] laneReady;
    logic                  inFire;

    // Every lane sees the data but only the selected one sees valid
    genvar i;
    generate
        for (i = 0; i < LANE_COUNT; i++) begin : genLane
            assign laneValid[i]   = inValid && (lanePtr == PTR_WIDTH'(i));
            assign lanes[i].valid = laneValid[i];
            assign lanes[i].bot   = inBot;
            assign lanes[i].last  = inLast;
            assign laneReady[i]   = lanes[i].ready;
        end
    endgenerate

    assign inReady = laneReady[lanePtr];
    assign inFire  = inValid && inReady;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= dispatchIdle;
            lanePtr <= '0;
        end else if (inFire) begin
            if (inLast) begin
                // Next batch goes to the next lane
                state <= dispatchIdle;
                if (lanePtr == PTR_WIDTH'(LANE_COUNT - 1)) begin
                    lanePtr <= '0;
                end else begin
                    lanePtr <= lanePtr + 1'b1;
                end
            end else begin
                state <= dispatchInBatch;
            end
        end
    end

    // Handshake is routed to one lane only
    oneLaneValid: assert property (@(posedge clk) disable iff (rst)
        $onehot0(laneValid))
        else $error("more than one lane sees valid");

    // A started batch is never stalled by its lane
    openBatchReady: assert property (@(posedge clk) disable iff (rst)
        state == dispatchInBatch |-> inReady)
        else $error("lane stalled an open batch");

endmodule

// ==== source/aggregatingLane.sv ====
`timescale 1ns/1ps

module aggregatingLane import botAggregatePkg::*; (
    input  logic           clk,
    input  logic           rst,
    botStreamIf.sink       bots,
    resultStreamIf.source  result
);

    localparam int POP_WIDTH = $clog2(BOT_WIDTH + 1);

    laneStateT state;
    logic      awake;
    logic      botFire;
    logic      resultFire;

    // Capture register for the accepted bot
    logic capValid;
    logic capLast;
    botT  capBot;

    // Popcount of the captured bot
    logic                 popValid;
    logic                 popLast;
    logic [POP_WIDTH-1:0] popCount;

    // Running totals and the held result
    logic [SUM_WIDTH-1:0]   accSum;
    logic [COUNT_WIDTH-1:0] accCount;
    logic [SUM_WIDTH-1:0]   holdSum;
    logic [COUNT_WIDTH-1:0] holdCount;

    // Stop taking bots once a last bot is inside the pipe
    // The hold register has room for one batch only
    assign bots.ready = awake && (state == laneCollecting)
                        && !(capValid && capLast) && !(popValid && popLast);

    assign botFire    = bots.valid && bots.ready;
    assign resultFire = result.valid && result.ready;

    assign result.valid = (state == laneHolding);
    assign result.sum   = holdSum;
    assign result.count = holdCount;

    always_ff @(posedge clk) begin
        if (rst) begin
            awake    <= 1'b0;
            state    <= laneCollecting;
            capValid <= 1'b0;
            popValid <= 1'b0;
            accSum   <= '0;
            accCount <= '0;
        end else begin
            awake    <= 1'b1;
            capValid <= botFire;
            popValid <= capValid;
            if (resultFire) begin
                state <= laneCollecting;
            end
            if (popValid) begin
                if (popLast) begin
                    // Totals move to the hold register and a fresh batch starts
                    state    <= laneHolding;
                    accSum   <= '0;
                    accCount <= '0;
                end else begin
                    accSum   <= accSum + SUM_WIDTH'(popCount);
                    accCount <= accCount + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (botFire) begin
            capBot  <= bots.bot;
            capLast <= bots.last;
        end
        if (capValid) begin
            popCount <= POP_WIDTH'($countones(capBot));
            popLast  <= capLast;
        end
        if (popValid && popLast) begin
            holdSum   <= accSum + SUM_WIDTH'(popCount);
            holdCount <= accCount + 1'b1;
        end
    end

    noBotWhileHolding: assert property (@(posedge clk) disable iff (rst)
        botFire |-> state != laneHolding)
        else $error("bot accepted while lane holds a result");

endmodule

// ==== source/resultCollector.sv ====
`timescale 1ns/1ps

module resultCollector import botAggregatePkg::*; #(
    parameter int LANE_COUNT      = 4,
    parameter int FIFO_DEPTH_LOG2 = 4
) (
    input  logic                   clk,
    input  logic                   rst,
    resultStreamIf.sink            lanes [LANE_COUNT],
    output logic                   resultValid,
    input  logic                   resultReady,
    output logic [SUM_WIDTH-1:0]   resultSum,
    output logic [COUNT_WIDTH-1:0] resultCount
);

    localparam int PTR_WIDTH  = (LANE_COUNT > 1) ? $clog2(LANE_COUNT) : 1;
    localparam int FIFO_DEPTH = 1 << FIFO_DEPTH_LOG2;

    logic [PTR_WIDTH-1:0]  drainPtr;
    logic [LANE_COUNT-1:0] laneValid;
    batchResultT           laneResult [LANE_COUNT];

    // Register-based results FIFO
    batchResultT                fifoMem [FIFO_DEPTH];
    batchResultT                fifoHead;
    logic [FIFO_DEPTH_LOG2-1:0] wrPtr;
    logic [FIFO_DEPTH_LOG2-1:0] rdPtr;
    logic [FIFO_DEPTH_LOG2:0]   occupancy;
    logic                       fifoFull;
    logic                       fifoWrite;
    logic                       fifoRead;

    // Only the drain lane is offered ready so batches leave in order
    genvar i;
    generate
        for (i = 0; i < LANE_COUNT; i++) begin : genLane
            assign laneValid[i]        = lanes[i].valid;
            assign laneResult[i].sum   = lanes[i].sum;
            assign laneResult[i].count = lanes[i].count;
            assign lanes[i].ready      = (drainPtr == PTR_WIDTH'(i)) && !fifoFull;
        end
    endgenerate

    assign fifoFull  = (occupancy == (FIFO_DEPTH_LOG2 + 1)'(FIFO_DEPTH));
    assign fifoWrite = laneValid[drainPtr] && !fifoFull;
    assign fifoRead  = resultValid && resultReady;

    always_ff @(posedge clk) begin
        if (rst) begin
            drainPtr  <= '0;
            wrPtr     <= '0;
            rdPtr     <= '0;
            occupancy <= '0;
        end else begin
            if (fifoWrite) begin
                wrPtr <= wrPtr + 1'b1;
                if (drainPtr == PTR_WIDTH'(LANE_COUNT - 1)) begin
                    drainPtr <= '0;
                end else begin
                    drainPtr <= drainPtr + 1'b1;
                end
            end
            if (fifoRead) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({fifoWrite, fifoRead})
                2'b10:   occupancy <= occupancy + 1'b1;
                2'b01:   occupancy <= occupancy - 1'b1;
                default: occupancy <= occupancy;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (fifoWrite) begin
            fifoMem[wrPtr] <= laneResult[drainPtr];
        end
    end

    // Head is visible one cycle after the write lands
    assign fifoHead    = fifoMem[rdPtr];
    assign resultValid = (occupancy != '0);
    assign resultSum   = fifoHead.sum;
    assign resultCount = fifoHead.count;

    noWriteWhenFull: assert property (@(posedge clk) disable iff (rst)
        fifoWrite |-> occupancy < FIFO_DEPTH)
        else $error("results FIFO written while full");

    noReadWhenEmpty: assert property (@(posedge clk) disable iff (rst)
        fifoRead |-> occupancy != '0)
        else $error("results FIFO read while empty");

endmodule

// ==== source/aggregatingArray.sv ====
`timescale 1ns/1ps

module aggregatingArray import botAggregatePkg::*; #(
    parameter int LANE_COUNT      = 4,
    parameter int FIFO_DEPTH_LOG2 = 4
) (
    input  logic                   clk,
    input  logic                   rst,

    // Input side
    input  logic                   inValid,
    output logic                   inReady,
    input  botT                    inBot,
    input  logic                   inLast,

    // Output side
    output logic                   resultValid,
    input  logic                   resultReady,
    output logic [SUM_WIDTH-1:0]   resultSum,
    output logic [COUNT_WIDTH-1:0] resultCount
);

    botStreamIf    laneBots    [LANE_COUNT] ();
    resultStreamIf laneResults [LANE_COUNT] ();

    batchDispatcher #(
        .LANE_COUNT(LANE_COUNT)
    ) dispatcher (
        .clk     (clk),
        .rst     (rst),
        .inValid (inValid),
        .inLast  (inLast),
        .inBot   (inBot),
        .inReady (inReady),
        .lanes   (laneBots)
    );

    // One aggregating lane per batch slot in the round robin
    genvar i;
    generate
        for (i = 0; i < LANE_COUNT; i++) begin : genLane
            aggregatingLane lane (
                .clk    (clk),
                .rst    (rst),
                .bots   (laneBots[i]),
                .result (laneResults[i])
            );
        end
    endgenerate

    resultCollector #(
        .LANE_COUNT      (LANE_COUNT),
        .FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2)
    ) collector (
        .clk         (clk),
        .rst         (rst),
        .lanes       (laneResults),
        .resultValid (resultValid),
        .resultReady (resultReady),
        .resultSum   (resultSum),
        .resultCount (resultCount)
    );

endmodule

// ==== dv/clockGen.sv ====
`timescale 1ns/1ps

module clockGen #(
    parameter int HALF_PERIOD  = 2,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // Reset drops just after a rising edge, like the rest of the stimulus
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

// ==== dv/aggregatingArrayTb.sv ====
`timescale 1ns/1ps

module aggregatingArrayTb import botAggregatePkg::*;;

    logic                   clk;
    logic                   rst;
    logic                   inValid;
    logic                   inReady;
    botT                    inBot;
    logic                   inLast;
    logic                   resultValid;
    logic                   resultReady;
    logic [SUM_WIDTH-1:0]   resultSum;
    logic [COUNT_WIDTH-1:0] resultCount;

    integer seed = 20346;

    // Output side control, owned by the main sequence
    logic holdOutput = 1'b0;
    logic stallOutput = 1'b0;
    logic sawStall = 1'b0;

    // Reference model state
    batchResultT            expected [$];
    batchResultT            newEntry;
    logic [SUM_WIDTH-1:0]   runSum;
    logic [COUNT_WIDTH-1:0] runCount;
    logic                   headValid = 1'b0;
    logic [SUM_WIDTH-1:0]   headSum;
    logic [COUNT_WIDTH-1:0] headCount;
    int botsSent = 0;
    int batchesSent = 0;
    int resultsSeen = 0;
    int cycleCount = 0;

    clockGen clocks (
        .clk (clk),
        .rst (rst)
    );

    aggregatingArray UUT (
        .clk         (clk),
        .rst         (rst),
        .inValid     (inValid),
        .inReady     (inReady),
        .inBot       (inBot),
        .inLast      (inLast),
        .resultValid (resultValid),
        .resultReady (resultReady),
        .resultSum   (resultSum),
        .resultCount (resultCount)
    );

    task automatic reportFailure(input string msg);
        $display("FAIL at %0t ns: %s", $time, msg);
        $display("Simulation failed");
        $fatal(1, "stopping at the first error");
    endtask

    // Number of true entries in one truth table
    function automatic logic [SUM_WIDTH-1:0] countTrueEntries(input botT bot);
        logic [SUM_WIDTH-1:0] total;
        total = '0;
        for (int b = 0; b < BOT_WIDTH; b++) begin
            total = total + SUM_WIDTH'(bot[b]);
        end
        return total;
    endfunction

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > 8 * botsSent + 2000) begin
            reportFailure($sformatf("timeout after %0d cycles", cycleCount));
        end
    end

    // Model follows every transfer on both sides
    always @(posedge clk) begin
        if (rst) begin
            runSum   = '0;
            runCount = '0;
        end else begin
            if (inValid && inReady) begin
                runSum   = runSum + countTrueEntries(inBot);
                runCount = runCount + 1'b1;
                botsSent++;
                if (inLast) begin
                    newEntry.sum   = runSum;
                    newEntry.count = runCount;
                    expected.push_back(newEntry);
                    batchesSent++;
                    runSum   = '0;
                    runCount = '0;
                end
            end
            if (resultValid && resultReady) begin
                if (expected.size() > 0) begin
                    void'(expected.pop_front());
                end
                resultsSeen++;
            end
            headValid = (expected.size() > 0);
            if (headValid) begin
                headSum   = expected[0].sum;
                headCount = expected[0].count;
            end
        end
    end

    resetQuiet: assert property (@(posedge clk)
        cycleCount > 0 && (rst || $past(rst)) |-> !resultValid && !inReady)
        else reportFailure("resultValid or inReady high during or right after reset");

    resultMatches: assert property (@(posedge clk) disable iff (rst)
        resultValid && resultReady |->
            headValid && resultSum == headSum && resultCount == headCount)
        else reportFailure($sformatf("result sum %0d count %0d, expected sum %0d count %0d",
            resultSum, resultCount, headSum, headCount));

    inputHeld: assert property (@(posedge clk) disable iff (rst)
        inValid && !inReady |=> inValid && $stable(inBot) && $stable(inLast))
        else reportFailure("input bot changed while waiting for inReady");

    outputHeld: assert property (@(posedge clk) disable iff (rst)
        resultValid && !resultReady |=>
            resultValid && $stable(resultSum) && $stable(resultCount))
        else reportFailure("result changed while waiting for resultReady");

    // Consumer side
    initial begin
        resultReady = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            if (holdOutput) begin
                resultReady = 1'b0;
            end else if (stallOutput) begin
                resultReady = (($random(seed) & 3) != 0);
            end else begin
                resultReady = 1'b1;
            end
        end
    end

    // Offers one bot and returns 1 ns after the edge that took it
    task automatic sendBot(input botT bot, input logic last, input int gapMax);
        int   gap;
        int   waited;
        logic accepted;
        gap = (gapMax > 0) ? int'({$random(seed)} % (gapMax + 1)) : 0;
        if (gap > 0) begin
            inValid = 1'b0;
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
        end
        inValid = 1'b1;
        inBot   = bot;
        inLast  = last;
        waited  = 0;
        do begin
            accepted = inReady;
            @(posedge clk);
            #1;
            waited++;
            // Input blocked long enough, let the results drain
            if (holdOutput && waited > 40) begin
                sawStall   = 1'b1;
                holdOutput = 1'b0;
            end
        end while (!accepted);
    endtask

    task automatic sendBatch(input int length, input int gapMax);
        for (int n = 0; n < length; n++) begin
            sendBot(botT'($random(seed)), n == length - 1, gapMax);
        end
    endtask

    task automatic waitDrained();
        inValid = 1'b0;
        inLast  = 1'b0;
        while (resultsSeen != batchesSent) begin
            @(posedge clk);
            #1;
        end
    endtask

    initial begin
        inValid = 1'b0;
        inBot   = '0;
        inLast  = 1'b0;
        @(negedge rst);
        @(posedge clk);
        #1;

        // Single-bot batches with known popcounts
        sendBot('0, 1'b1, 0);
        sendBot('1, 1'b1, 0);
        for (int i = 0; i < BOT_WIDTH; i++) begin
            sendBot(botT'(1) << i, 1'b1, 0);
        end
        waitDrained();

        // Several trips around the lanes
        for (int b = 0; b < 15; b++) begin
            sendBatch(1 + int'({$random(seed)} % 20), 0);
        end
        waitDrained();

        // Results held back until the input stalls
        holdOutput = 1'b1;
        for (int b = 0; b < 24; b++) begin
            sendBatch(1 + int'({$random(seed)} % 4), 0);
        end
        waitDrained();
        stallSeen: assert (sawStall)
            else reportFailure("inReady never fell while results were held back");

        // Gaps on the input and random stalls on the output
        stallOutput = 1'b1;
        for (int b = 0; b < 40; b++) begin
            sendBatch(1 + int'({$random(seed)} % 20), 3);
        end
        waitDrained();

        if (expected.size() == 0) begin
            $display("Simulation passed");
            $finish;
        end else begin
            reportFailure("expected results left over at the end");
        end
    end

endmodule

// ==== all.f ====
source/botAggregatePkg.sv
source/streamIfs.sv
source/batchDispatcher.sv
source/aggregatingLane.sv
source/resultCollector.sv
source/aggregatingArray.sv
dv/clockGen.sv
dv/aggregatingArrayTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the aggregating array testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f all.f \
    --top-module aggregatingArrayTb \
    -o aggregatingArraySim

# A $fatal in the testbench makes this step return a failing status
./obj_dir/aggregatingArraySim
